// File: hdl/segre_consts.svh
`ifndef SEGRE_CONSTS_SVH
`define SEGRE_CONSTS_SVH

// Datapath word width
`define SEGRE_WORD_SIZE 32

// Register index width
`define SEGRE_REG_ADDR_W 5

// Result queue depth and the producer's starting credits
`define SEGRE_RES_DEPTH 4

// Credits held toward the consumer after reset
`define SEGRE_OUT_CREDITS 2

`endif

// File: hdl/segre_pkg.sv
`include "segre_consts.svh"

package segre_pkg;

    // Branch and jump operations are not part of this path
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_MUL,
        ALU_MULH,
        ALU_MULHU,
        ALU_MULHSU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_opcode_e;

    typedef logic [`SEGRE_WORD_SIZE-1:0] word_t;

    typedef logic [`SEGRE_REG_ADDR_W-1:0] reg_addr_t;

    // Destination and error flag carried alongside each result
    typedef struct packed {
        reg_addr_t rd;
        logic      illegal;
    } res_tag_t;

endpackage : segre_pkg

// File: hdl/segre_decode.sv
`timescale 1ns/1ps
`include "segre_consts.svh"

module segre_decode (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  logic                    in_valid_i,
    input  segre_pkg::word_t        instr_i,
    input  segre_pkg::word_t        rs1_val_i,
    input  segre_pkg::word_t        rs2_val_i,

    output logic                    dec_valid_o,
    output segre_pkg::alu_opcode_e  dec_opcode_o,
    output segre_pkg::word_t        dec_src_a_o,
    output segre_pkg::word_t        dec_src_b_o,
    output segre_pkg::res_tag_t     dec_tag_o
);

    import segre_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MEXT    = 7'b0000001;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       imm_i;
    alu_opcode_e opcode_d;
    word_t       src_b_d;
    logic        illegal_d;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign imm_i  = {{(`SEGRE_WORD_SIZE-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        opcode_d  = ALU_ADD;
        src_b_d   = rs2_val_i;
        illegal_d = 1'b0;

        if (opcode == OPC_OP) begin
            if (funct7 == F7_MEXT) begin
                case (funct3)
                    3'b000: opcode_d = ALU_MUL;
                    3'b001: opcode_d = ALU_MULH;
                    3'b010: opcode_d = ALU_MULHSU;
                    3'b011: opcode_d = ALU_MULHU;
                    3'b100: opcode_d = ALU_DIV;
                    3'b101: opcode_d = ALU_DIVU;
                    3'b110: opcode_d = ALU_REM;
                    default: opcode_d = ALU_REMU;
                endcase
            end else if (funct7 == F7_ALT) begin
                // Only SUB and SRA use the alternate encoding
                if (funct3 == 3'b000) begin
                    opcode_d = ALU_SUB;
                end else if (funct3 == 3'b101) begin
                    opcode_d = ALU_SRA;
                end else begin
                    illegal_d = 1'b1;
                end
            end else if (funct7 == F7_BASE) begin
                case (funct3)
                    3'b000: opcode_d = ALU_ADD;
                    3'b001: opcode_d = ALU_SLL;
                    3'b010: opcode_d = ALU_SLT;
                    3'b011: opcode_d = ALU_SLTU;
                    3'b100: opcode_d = ALU_XOR;
                    3'b101: opcode_d = ALU_SRL;
                    3'b110: opcode_d = ALU_OR;
                    default: opcode_d = ALU_AND;
                endcase
            end else begin
                illegal_d = 1'b1;
            end
        end else if (opcode == OPC_OP_IMM) begin
            src_b_d = imm_i;
            case (funct3)
                3'b000: opcode_d = ALU_ADD;
                3'b001: begin
                    opcode_d  = ALU_SLL;
                    illegal_d = (funct7 != F7_BASE);
                end
                3'b010: opcode_d = ALU_SLT;
                3'b011: opcode_d = ALU_SLTU;
                3'b100: opcode_d = ALU_XOR;
                3'b101: begin
                    // SRAI keeps funct7 in the upper immediate bits
                    opcode_d  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    illegal_d = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
                3'b110: opcode_d = ALU_OR;
                default: opcode_d = ALU_AND;
            endcase
        end else begin
            illegal_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            dec_opcode_o      <= opcode_d;
            dec_src_a_o       <= rs1_val_i;
            dec_src_b_o       <= src_b_d;
            dec_tag_o.rd      <= instr_i[11:7];
            dec_tag_o.illegal <= illegal_d;
        end
    end

endmodule : segre_decode

// File: hdl/segre_alu.sv
`timescale 1ns/1ps
`include "segre_consts.svh"

module segre_alu (
    input  segre_pkg::alu_opcode_e alu_opcode_i,
    input  segre_pkg::word_t       alu_src_a_i,
    input  segre_pkg::word_t       alu_src_b_i,

    output segre_pkg::word_t       alu_res_o
);

    import segre_pkg::*;

    localparam int W = `SEGRE_WORD_SIZE;

    localparam word_t MOST_NEG = {1'b1, {(W-1){1'b0}}};
    localparam word_t MINUS_ONE = {W{1'b1}};

    logic [4:0]     shamt;
    logic [2*W-1:0] mul_ss;
    logic [2*W-1:0] mul_uu;
    logic [2*W-1:0] mul_su;
    logic           div_zero;
    logic           div_ovf;
    word_t          div_res;
    word_t          divu_res;
    word_t          rem_res;
    word_t          remu_res;

    assign shamt = alu_src_b_i[4:0];

    always_comb begin
        // Extend to the full product width before multiplying
        mul_ss = $signed({{W{alu_src_a_i[W-1]}}, alu_src_a_i})
               * $signed({{W{alu_src_b_i[W-1]}}, alu_src_b_i});
        mul_uu = {{W{1'b0}}, alu_src_a_i} * {{W{1'b0}}, alu_src_b_i};
        mul_su = {{W{alu_src_a_i[W-1]}}, alu_src_a_i} * {{W{1'b0}}, alu_src_b_i};
    end

    assign div_zero = (alu_src_b_i == '0);
    assign div_ovf  = (alu_src_a_i == MOST_NEG) && (alu_src_b_i == MINUS_ONE);

    always_comb begin
        if (div_zero) begin
            div_res  = MINUS_ONE;
            divu_res = MINUS_ONE;
            rem_res  = alu_src_a_i;
            remu_res = alu_src_a_i;
        end else begin
            divu_res = alu_src_a_i / alu_src_b_i;
            remu_res = alu_src_a_i % alu_src_b_i;
            if (div_ovf) begin
                div_res = alu_src_a_i;
                rem_res = '0;
            end else begin
                div_res = word_t'($signed(alu_src_a_i) / $signed(alu_src_b_i));
                rem_res = word_t'($signed(alu_src_a_i) % $signed(alu_src_b_i));
            end
        end
    end

    always_comb begin
        case (alu_opcode_i)
            ALU_ADD   : alu_res_o = alu_src_a_i + alu_src_b_i;
            ALU_SUB   : alu_res_o = alu_src_a_i - alu_src_b_i;
            ALU_SLL   : alu_res_o = alu_src_a_i << shamt;
            ALU_SRL   : alu_res_o = alu_src_a_i >> shamt;
            ALU_SRA   : alu_res_o = word_t'($signed(alu_src_a_i) >>> shamt);
            ALU_XOR   : alu_res_o = alu_src_a_i ^ alu_src_b_i;
            ALU_OR    : alu_res_o = alu_src_a_i | alu_src_b_i;
            ALU_AND   : alu_res_o = alu_src_a_i & alu_src_b_i;
            ALU_SLT   : alu_res_o = {{(W-1){1'b0}}, $signed(alu_src_a_i) < $signed(alu_src_b_i)};
            ALU_SLTU  : alu_res_o = {{(W-1){1'b0}}, alu_src_a_i < alu_src_b_i};
            ALU_MUL   : alu_res_o = mul_ss[W-1:0];
            ALU_MULH  : alu_res_o = mul_ss[2*W-1:W];
            ALU_MULHU : alu_res_o = mul_uu[2*W-1:W];
            ALU_MULHSU: alu_res_o = mul_su[2*W-1:W];
            ALU_DIV   : alu_res_o = div_res;
            ALU_DIVU  : alu_res_o = divu_res;
            ALU_REM   : alu_res_o = rem_res;
            ALU_REMU  : alu_res_o = remu_res;
            default   : alu_res_o = '0;
        endcase
    end

endmodule : segre_alu

// File: hdl/segre_execute.sv
`timescale 1ns/1ps

module segre_execute (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    input  logic                   dec_valid_i,
    input  segre_pkg::alu_opcode_e dec_opcode_i,
    input  segre_pkg::word_t       dec_src_a_i,
    input  segre_pkg::word_t       dec_src_b_i,
    input  segre_pkg::res_tag_t    dec_tag_i,

    output logic                   ex_valid_o,
    output segre_pkg::word_t       ex_result_o,
    output segre_pkg::res_tag_t    ex_tag_o
);

    import segre_pkg::*;

    word_t alu_res;

    segre_alu i_alu (
        .alu_opcode_i (dec_opcode_i),
        .alu_src_a_i  (dec_src_a_i),
        .alu_src_b_i  (dec_src_b_i),
        .alu_res_o    (alu_res)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i) begin
            // Illegal encodings leave with a zero value
            ex_result_o <= dec_tag_i.illegal ? '0 : alu_res;
            ex_tag_o    <= dec_tag_i;
        end
    end

endmodule : segre_execute

// File: hdl/segre_credit_fifo.sv
`timescale 1ns/1ps

module segre_credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk_i,
    input  logic arst_n_i,

    input  logic push_i,
    input  T     push_data_i,

    input  logic pop_i,
    output T     pop_data_o,

    output logic empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    // Head entry is visible without a read cycle
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : segre_credit_fifo

// File: hdl/segre_result.sv
`timescale 1ns/1ps
`include "segre_consts.svh"

module segre_result (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  logic                 ex_valid_i,
    input  segre_pkg::word_t     ex_result_i,
    input  segre_pkg::res_tag_t  ex_tag_i,

    input  logic                 res_credit_i,
    output logic                 res_valid_o,
    output segre_pkg::word_t     res_data_o,
    output segre_pkg::reg_addr_t res_rd_o,
    output logic                 res_err_o,

    output logic                 in_credit_o
);

    import segre_pkg::*;

    localparam int CREDIT_W = $clog2(`SEGRE_OUT_CREDITS + 1);

    logic [CREDIT_W-1:0] out_credits;
    logic                data_empty;
    logic                tag_empty;
    logic                pop;
    res_tag_t            head_tag;

    segre_credit_fifo #(
        .T     (word_t),
        .DEPTH (`SEGRE_RES_DEPTH)
    ) i_data_fifo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (ex_valid_i),
        .push_data_i (ex_result_i),
        .pop_i       (pop),
        .pop_data_o  (res_data_o),
        .empty_o     (data_empty)
    );

    segre_credit_fifo #(
        .T     (res_tag_t),
        .DEPTH (`SEGRE_RES_DEPTH)
    ) i_tag_fifo (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (ex_valid_i),
        .push_data_i (ex_tag_i),
        .pop_i       (pop),
        .pop_data_o  (head_tag),
        .empty_o     (tag_empty)
    );

    // Send the head entry whenever a consumer credit is held
    assign pop         = !data_empty && !tag_empty && (out_credits != '0);
    assign res_valid_o = pop;
    assign res_rd_o    = head_tag.rd;
    assign res_err_o   = head_tag.illegal;
    assign in_credit_o = pop;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_credits <= CREDIT_W'(`SEGRE_OUT_CREDITS);
        end else begin
            out_credits <= out_credits - CREDIT_W'(pop) + CREDIT_W'(res_credit_i);
        end
    end

endmodule : segre_result

// File: hdl/segre_exec_top.sv
`timescale 1ns/1ps

module segre_exec_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  logic                 in_valid_i,
    input  segre_pkg::word_t     instr_i,
    input  segre_pkg::word_t     rs1_val_i,
    input  segre_pkg::word_t     rs2_val_i,
    output logic                 in_credit_o,

    output logic                 res_valid_o,
    output segre_pkg::word_t     res_data_o,
    output segre_pkg::reg_addr_t res_rd_o,
    output logic                 res_err_o,
    input  logic                 res_credit_i
);

    import segre_pkg::*;

    logic        dec_valid;
    alu_opcode_e dec_opcode;
    word_t       dec_src_a;
    word_t       dec_src_b;
    res_tag_t    dec_tag;

    logic        ex_valid;
    word_t       ex_result;
    res_tag_t    ex_tag;

    segre_decode i_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .instr_i      (instr_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .dec_valid_o  (dec_valid),
        .dec_opcode_o (dec_opcode),
        .dec_src_a_o  (dec_src_a),
        .dec_src_b_o  (dec_src_b),
        .dec_tag_o    (dec_tag)
    );

    segre_execute i_execute (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .dec_valid_i  (dec_valid),
        .dec_opcode_i (dec_opcode),
        .dec_src_a_i  (dec_src_a),
        .dec_src_b_i  (dec_src_b),
        .dec_tag_i    (dec_tag),
        .ex_valid_o   (ex_valid),
        .ex_result_o  (ex_result),
        .ex_tag_o     (ex_tag)
    );

    segre_result i_result (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .ex_valid_i   (ex_valid),
        .ex_result_i  (ex_result),
        .ex_tag_i     (ex_tag),
        .res_credit_i (res_credit_i),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_rd_o     (res_rd_o),
        .res_err_o    (res_err_o),
        .in_credit_o  (in_credit_o)
    );

endmodule : segre_exec_top

// File: test/segre_checker.sv
`timescale 1ns/1ps
`include "segre_consts.svh"

module segre_checker (
    input logic clk_i,
    input logic arst_n_i,
    input logic res_valid_i,
    input logic res_credit_i,
    input logic in_credit_i
);

    // Consumer credits held by the DUT as seen at the ports
    int credits;
    int transfers;
    int returns;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits   <= `SEGRE_OUT_CREDITS;
            transfers <= 0;
            returns   <= 0;
        end else begin
            credits <= credits - (res_valid_i ? 1 : 0) + (res_credit_i ? 1 : 0);
            if (res_valid_i) begin
                transfers <= transfers + 1;
            end
            if (in_credit_i) begin
                returns <= returns + 1;
            end
        end
    end

    credit_held_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        res_valid_i |-> (credits > 0))
        else $error("result sent while no consumer credit was held");

    credit_return_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (returns + (in_credit_i ? 1 : 0)) <= (transfers + (res_valid_i ? 1 : 0)))
        else $error("more input credits returned than results sent");

    valid_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(res_valid_i))
        else $error("result valid is unknown after reset");

endmodule : segre_checker

// File: test/segre_tb.sv
`timescale 1ns/1ps
`include "segre_consts.svh"

module segre_tb;

    import segre_pkg::*;

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 8;
    localparam int N_OPIMM          = 64;
    localparam int N_OP             = 64;
    localparam int N_MEXT           = 80;
    localparam int N_ILLEGAL        = 40;
    localparam int N_STRESS         = 96;
    localparam int TOTAL_INSTR      = 1 + N_OPIMM + N_OP + N_MEXT + N_ILLEGAL + N_STRESS;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int TIMEOUT_NS = (TOTAL_INSTR * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD;
    localparam int RES_LATENCY      = 3;

    localparam int K_OPIMM   = 0;
    localparam int K_OP      = 1;
    localparam int K_MEXT    = 2;
    localparam int K_ILLEGAL = 3;
    localparam int K_STRESS  = 4;

    logic      clk_i;
    logic      arst_n_i;
    logic      in_valid_i;
    word_t     instr_i;
    word_t     rs1_val_i;
    word_t     rs2_val_i;
    logic      in_credit_o;
    logic      res_valid_o;
    word_t     res_data_o;
    reg_addr_t res_rd_o;
    logic      res_err_o;
    logic      res_credit_i;

    integer      seed;
    string       cur_test;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          prod_credits;
    int          owed_credits;
    int          credits_given;
    int          transfers;
    int          cycle;
    int          last_latency;
    // Chance out of 16 that the consumer returns a credit in a cycle
    int          credit_pct;
    // Expected entries as {err, rd, data}
    logic [37:0] exp_q[$];
    int          sent_q[$];

    segre_exec_top i_dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .instr_i      (instr_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .in_credit_o  (in_credit_o),
        .res_valid_o  (res_valid_o),
        .res_data_o   (res_data_o),
        .res_rd_o     (res_rd_o),
        .res_err_o    (res_err_o),
        .res_credit_i (res_credit_i)
    );

    bind segre_exec_top segre_checker i_checker (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .res_valid_i  (res_valid_o),
        .res_credit_i (res_credit_i),
        .in_credit_i  (in_credit_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic word_t base_op(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? word_t'(longint'($signed(a)) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic word_t mext_op(input logic [2:0] f3, input word_t a, input word_t b);
        logic [63:0] pu;
        word_t       hsu;
        word_t       hs;
        longint      sa;
        longint      sb;
        pu  = {32'b0, a} * {32'b0, b};
        // Signed high halves from the unsigned product with sign corrections
        hsu = pu[63:32] - (a[31] ? b : 32'h0);
        hs  = hsu - (b[31] ? a : 32'h0);
        sa  = longint'($signed(a));
        sb  = longint'($signed(b));
        case (f3)
            3'b000: return pu[31:0];
            3'b001: return hs;
            3'b010: return hsu;
            3'b011: return pu[63:32];
            3'b100: return (b == '0) ? 32'hffff_ffff : word_t'(sa / sb);
            3'b101: return (b == '0) ? 32'hffff_ffff : a / b;
            3'b110: return (b == '0) ? a : word_t'(sa % sb);
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    // Returns {illegal, value}
    function automatic logic [32:0] model_result(input word_t instr, input word_t a,
                                                 input word_t rs2);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      imm;
        word_t      res;
        logic       err;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        imm = {{20{instr[31]}}, instr[31:20]};
        err = 1'b0;
        res = '0;
        if (opc == 7'h13) begin
            err = (f3 == 3'b001 && f7 != 7'h00)
                || (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
            res = base_op(f3, f3 == 3'b101 && f7 == 7'h20, a, imm);
        end else if (opc == 7'h33 && f7 == 7'h00) begin
            res = base_op(f3, 1'b0, a, rs2);
        end else if (opc == 7'h33 && f7 == 7'h20) begin
            err = (f3 != 3'b000) && (f3 != 3'b101);
            res = base_op(f3, 1'b1, a, rs2);
        end else if (opc == 7'h33 && f7 == 7'h01) begin
            res = mext_op(f3, a, rs2);
        end else begin
            err = 1'b1;
        end
        return {err, err ? 32'h0 : res};
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_error(input string what);
        $display("Error in %s: %s", cur_test, what);
        errors++;
        test_errors++;
    endtask

    // Sample outputs after the falling edge and then drive inputs
    task automatic step(input logic send, input word_t instr, input word_t a, input word_t b);
        logic [37:0] exp;
        logic [32:0] model;
        logic [3:0]  r;
        int          held;
        logic        exp_valid;
        @(negedge clk_i);
        cycle++;
        // Head leaves once it has crossed the pipeline and a credit is held
        held      = `SEGRE_OUT_CREDITS - transfers + credits_given;
        exp_valid = 1'b0;
        if (sent_q.size() > 0) begin
            exp_valid = (cycle - sent_q[0] >= RES_LATENCY) && (held > 0);
        end
        check_value("result valid", 32'(exp_valid), 32'(res_valid_o));
        check_value("credit return", 32'(exp_valid), 32'(in_credit_o));
        if (res_valid_o) begin
            transfers++;
            owed_credits++;
            if (transfers > credits_given + `SEGRE_OUT_CREDITS) begin
                note_error("more results were sent than credits were given");
            end
            if (exp_q.size() == 0) begin
                note_error("a result arrived with no instruction outstanding");
            end else begin
                exp          = exp_q.pop_front();
                last_latency = cycle - sent_q.pop_front();
                check_value("data", exp[31:0], res_data_o);
                check_value("rd", 32'(exp[36:32]), 32'(res_rd_o));
                check_value("err", 32'(exp[37]), 32'(res_err_o));
            end
        end
        if (in_credit_o) begin
            prod_credits++;
        end
        in_valid_i = send;
        instr_i    = instr;
        rs1_val_i  = a;
        rs2_val_i  = b;
        if (send) begin
            prod_credits--;
            model = model_result(instr, a, b);
            exp_q.push_back({model[32], instr[11:7], model[31:0]});
            sent_q.push_back(cycle);
        end
        r = 4'($random(seed));
        if (owed_credits > 0 && int'(r) < credit_pct) begin
            res_credit_i = 1'b1;
            owed_credits--;
            credits_given++;
        end else begin
            res_credit_i = 1'b0;
        end
    endtask

    task automatic gen_instr(input int kind, input int idx, output word_t instr,
                             output word_t a, output word_t b);
        word_t      r0;
        word_t      r3;
        logic [6:0] f7;
        logic [2:0] f3;
        int         k;
        r0 = $random(seed);
        a  = $random(seed);
        b  = $random(seed);
        r3 = $random(seed);
        f3 = r0[14:12];
        k  = (kind == K_STRESS) ? int'(r0[1:0]) : kind;
        case (k)
            K_OPIMM: begin
                f7 = r0[31:25];
                if (f3 == 3'b001) f7 = 7'h00;
                if (f3 == 3'b101) f7 = r0[30] ? 7'h20 : 7'h00;
                instr = {f7, r0[24:7], 7'h13};
            end
            K_OP: begin
                f7    = (r0[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                instr = {f7, r0[24:7], 7'h33};
            end
            K_MEXT: begin
                instr = {7'h01, r0[24:7], 7'h33};
                // Division by zero, signed overflow and MULHSU with negative a
                case (idx % 8)
                    0: begin
                        instr[14] = 1'b1;
                        b         = '0;
                    end
                    1: begin
                        instr[14] = 1'b1;
                        a         = 32'h8000_0000;
                        b         = 32'hffff_ffff;
                    end
                    2: begin
                        instr[14:12] = 3'b010;
                        a[31]        = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: begin
                case (r0[6:5])
                    2'd0: begin
                        instr = {r0[31:7], r3[6:0]};
                        if (r3[6:0] == 7'h13 || r3[6:0] == 7'h33) instr[6:0] = 7'h03;
                    end
                    2'd1: begin
                        f7 = r3[31:25];
                        if (f7 == 7'h00 || f7 == 7'h20 || f7 == 7'h01) f7 = 7'h7f;
                        instr = {f7, r0[24:7], 7'h33};
                    end
                    2'd2: begin
                        if (f3 == 3'b000 || f3 == 3'b101) f3 = 3'b111;
                        instr = {7'h20, r0[24:15], f3, r0[11:7], 7'h33};
                    end
                    default: begin
                        f3    = r3[0] ? 3'b001 : 3'b101;
                        instr = {r3[31:25] | 7'h40, r0[24:15], f3, r0[11:7], 7'h13};
                    end
                endcase
            end
        endcase
    endtask

    task automatic drain_results();
        credit_pct = 8;
        while (exp_q.size() > 0) begin
            step(1'b0, '0, '0, '0);
        end
        check_value("producer credits", `SEGRE_RES_DEPTH, prod_credits);
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic run_first_result();
        int k;
        cur_test    = "first result latency";
        test_errors = 0;
        for (k = 0; k < 6; k++) begin
            step(1'b0, '0, '0, '0);
            check_value("idle valid", 32'h0, 32'(res_valid_o));
            check_value("idle credit", 32'h0, 32'(in_credit_o));
        end
        // ADDI x9, x0, 5 with an operand of 0x10
        step(1'b1, {12'h005, 5'd0, 3'b000, 5'd9, 7'h13}, 32'h10, 32'h0);
        drain_results();
        check_value("latency", 32'(RES_LATENCY), 32'(last_latency));
        finish_test();
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        int         sent;
        word_t      instr;
        word_t      a;
        word_t      b;
        logic [1:0] r;
        cur_test    = name;
        test_errors = 0;
        sent        = 0;
        while (sent < count) begin
            if (kind == K_STRESS) begin
                // Alternate long stretches without and with credit returns
                credit_pct = ((cycle / 24) % 2 == 0) ? 0 : 12;
            end
            r = 2'($random(seed));
            if (prod_credits > 0 && r != 2'b00) begin
                gen_instr(kind, sent, instr, a, b);
                step(1'b1, instr, a, b);
                sent++;
            end else begin
                step(1'b0, '0, '0, '0);
            end
        end
        drain_results();
        finish_test();
    endtask

    initial begin
        seed          = 32'h35ed;
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        in_valid_i    = 1'b0;
        instr_i       = '0;
        rs1_val_i     = '0;
        rs2_val_i     = '0;
        res_credit_i  = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        prod_credits  = `SEGRE_RES_DEPTH;
        owed_credits  = 0;
        credits_given = 0;
        transfers     = 0;
        cycle         = 0;
        last_latency  = 0;
        credit_pct    = 8;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        run_first_result();
        run_test("OP-IMM random", K_OPIMM, N_OPIMM);
        run_test("OP base random", K_OP, N_OP);
        run_test("M extension", K_MEXT, N_MEXT);
        run_test("illegal encodings", K_ILLEGAL, N_ILLEGAL);
        run_test("credit back-pressure", K_STRESS, N_STRESS);
        $display("Summary: %0d tests run, %0d failed, %0d errors, %0d results",
                 tests_run, tests_failed, errors, transfers);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : segre_tb

// File: sim.f
+incdir+hdl
hdl/segre_pkg.sv
hdl/segre_decode.sv
hdl/segre_alu.sv
hdl/segre_execute.sv
hdl/segre_credit_fifo.sv
hdl/segre_result.sv
hdl/segre_exec_top.sv
test/segre_checker.sv
test/segre_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f sim.f --top-module segre_tb \
    --Mdir obj_dir -o segre_sim \
    && ./obj_dir/segre_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
